//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  insn_class_t;

  // Base opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_FENCE  = 7'b0001111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // ALU funct3
  localparam funct3_t F3_ADD  = 3'b000;  // ADD/SUB
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;  // SRL/SRA
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Branch funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Instruction classes
  localparam insn_class_t CLS_NOP    = 4'd0;  // FENCE and anything unknown
  localparam insn_class_t CLS_LUI    = 4'd1;
  localparam insn_class_t CLS_AUIPC  = 4'd2;
  localparam insn_class_t CLS_OPIMM  = 4'd3;
  localparam insn_class_t CLS_OP     = 4'd4;
  localparam insn_class_t CLS_BRANCH = 4'd5;
  localparam insn_class_t CLS_JAL    = 4'd6;
  localparam insn_class_t CLS_JALR   = 4'd7;
  localparam insn_class_t CLS_SYSTEM = 4'd8;

  localparam int    NUM_REGS   = 32;
  localparam word_t INSN_BYTES = 32'd4;
  localparam word_t RESET_PC   = 32'h0000_0000;

  typedef struct packed {
    insn_class_t cls;
    funct3_t     funct3;
    logic        alt;        // Bit 30, SUB/SRA select
    logic        writes_rd;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;        // Sign-extended per format
  } decoded_insn_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

endpackage

`default_nettype wire

//--- design/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  rv_pkg::word_t         insn,
  output rv_pkg::decoded_insn_t dec
);

  rv_pkg::opcode_t opcode;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   imm_u;
  logic            cls_writes;

  assign opcode = insn[6:0];

  // Immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};  // Upper 20 bits, low 12 zero

  always_comb begin
    dec.funct3 = insn[14:12];
    dec.alt    = insn[30];
    dec.rd     = insn[11:7];
    dec.rs1    = insn[19:15];
    dec.rs2    = insn[24:20];
    dec.cls    = rv_pkg::CLS_NOP;
    dec.imm    = imm_i;

    case (opcode)
      rv_pkg::OP_LUI: begin
        dec.cls = rv_pkg::CLS_LUI;
        dec.imm = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        dec.cls = rv_pkg::CLS_AUIPC;
        dec.imm = imm_u;
      end
      rv_pkg::OP_IMM:    dec.cls = rv_pkg::CLS_OPIMM;
      rv_pkg::OP_REG:    dec.cls = rv_pkg::CLS_OP;
      rv_pkg::OP_BRANCH: begin
        dec.cls = rv_pkg::CLS_BRANCH;
        dec.imm = imm_b;
      end
      rv_pkg::OP_JAL: begin
        dec.cls = rv_pkg::CLS_JAL;
        dec.imm = imm_j;
      end
      rv_pkg::OP_JALR:   dec.cls = rv_pkg::CLS_JALR;    // I-type offset
      rv_pkg::OP_SYSTEM: dec.cls = rv_pkg::CLS_SYSTEM;
      rv_pkg::OP_FENCE:  dec.cls = rv_pkg::CLS_NOP;     // No memory ordering to do
      default:           dec.cls = rv_pkg::CLS_NOP;
    endcase

    // Only these classes produce a register result
    cls_writes = dec.cls inside {rv_pkg::CLS_LUI, rv_pkg::CLS_AUIPC, rv_pkg::CLS_OPIMM,
                                 rv_pkg::CLS_OP, rv_pkg::CLS_JAL, rv_pkg::CLS_JALR};
    dec.writes_rd = cls_writes && (dec.rd != '0);  // x0 stays zero
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire              clk,
  input  wire              rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::retire_t  wr
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  // Write enable never targets x0, so entry zero keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // Combinational reads, new value seen next cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- design/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
  input  rv_pkg::decoded_insn_t dec,
  input  rv_pkg::word_t         pc,
  input  rv_pkg::word_t         rs1_data,
  input  rv_pkg::word_t         rs2_data,
  output rv_pkg::word_t         alu_result
);

  rv_pkg::word_t op_b;
  logic [4:0]    shamt;
  logic          use_alt;

  assign op_b  = (dec.cls == rv_pkg::CLS_OP) ? rs2_data : dec.imm;
  assign shamt = op_b[4:0];

  // In OPIMM bit 30 is immediate data except for SRAI
  assign use_alt = dec.alt && ((dec.cls == rv_pkg::CLS_OP) || (dec.funct3 == rv_pkg::F3_SR));

  always_comb begin
    alu_result = '0;
    case (dec.cls)
      rv_pkg::CLS_LUI:   alu_result = dec.imm;
      rv_pkg::CLS_AUIPC: alu_result = pc + dec.imm;
      rv_pkg::CLS_OPIMM, rv_pkg::CLS_OP: begin
        case (dec.funct3)
          rv_pkg::F3_ADD:  alu_result = use_alt ? rs1_data - op_b : rs1_data + op_b;
          rv_pkg::F3_SLL:  alu_result = rs1_data << shamt;
          rv_pkg::F3_SLT:  alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
          rv_pkg::F3_SLTU: alu_result = {31'b0, rs1_data < op_b};
          rv_pkg::F3_XOR:  alu_result = rs1_data ^ op_b;
          rv_pkg::F3_SR: begin
            if (use_alt) begin
              alu_result = $signed(rs1_data) >>> shamt;  // Arithmetic
            end else begin
              alu_result = rs1_data >> shamt;
            end
          end
          rv_pkg::F3_OR:   alu_result = rs1_data | op_b;
          rv_pkg::F3_AND:  alu_result = rs1_data & op_b;
          default:         alu_result = '0;
        endcase
      end
      default: alu_result = '0;  // Link value comes from the sequencer
    endcase
  end

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  rv_pkg::decoded_insn_t dec,
  input  rv_pkg::word_t         pc,
  input  rv_pkg::word_t         rs1_data,
  input  rv_pkg::word_t         rs2_data,
  output logic                  taken,
  output rv_pkg::word_t         target
);

  logic          cond;
  rv_pkg::word_t jalr_sum;

  always_comb begin
    case (dec.funct3)
      rv_pkg::F3_BEQ:  cond = rs1_data == rs2_data;
      rv_pkg::F3_BNE:  cond = rs1_data != rs2_data;
      rv_pkg::F3_BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::F3_BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::F3_BLTU: cond = rs1_data < rs2_data;
      rv_pkg::F3_BGEU: cond = rs1_data >= rs2_data;
      default:         cond = 1'b0;  // Reserved encodings never branch
    endcase
  end

  assign taken = cond && (dec.cls == rv_pkg::CLS_BRANCH);

  // JALR target is register relative with bit 0 dropped
  assign jalr_sum = rs1_data + dec.imm;
  assign target   = (dec.cls == rv_pkg::CLS_JALR) ? {jalr_sum[31:1], 1'b0} : pc + dec.imm;

endmodule

`default_nettype wire

//--- design/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer (
  input  wire                   clk,
  input  wire                   rst,
  input  rv_pkg::decoded_insn_t dec,
  input  wire                   taken,
  input  rv_pkg::word_t         target,
  input  rv_pkg::word_t         alu_result,
  output rv_pkg::word_t         pc,
  output rv_pkg::retire_t       retire,
  output logic                  halt
);

  rv_pkg::word_t link;
  rv_pkg::word_t next_pc;
  logic          is_jump;

  assign is_jump = (dec.cls == rv_pkg::CLS_JAL) || (dec.cls == rv_pkg::CLS_JALR);
  assign link    = pc + rv_pkg::INSN_BYTES;  // Also the fall-through pc
  assign next_pc = (taken || is_jump) ? target : link;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  always_comb begin
    retire.we   = dec.writes_rd && !rst;  // Nothing retires during reset
    retire.rd   = dec.rd;
    retire.data = is_jump ? link : alu_result;
  end

  // ECALL still advances pc
  assign halt = (dec.cls == rv_pkg::CLS_SYSTEM) && !rst;

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire             clk,
  input  wire             rst,
  input  rv_pkg::word_t   insn,
  output rv_pkg::word_t   pc,
  output rv_pkg::retire_t retire,
  output logic            halt
);

  rv_pkg::decoded_insn_t dec;
  rv_pkg::word_t         rs1_data;
  rv_pkg::word_t         rs2_data;
  rv_pkg::word_t         alu_result;
  rv_pkg::word_t         target;
  logic                  taken;

  insn_decoder u_dec (
    .insn (insn),
    .dec  (dec)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (retire)      // Write port fed by the retire trace
  );

  exec_alu u_alu (
    .dec        (dec),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result)
  );

  branch_unit u_br (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .taken    (taken),
    .target   (target)
  );

  pc_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .taken      (taken),
    .target     (target),
    .alu_result (alu_result),
    .pc         (pc),
    .retire     (retire),
    .halt       (halt)
  );

endmodule

`default_nettype wire

//--- bench/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

rv_pkg::word_t model_regs [rv_pkg::NUM_REGS];
rv_pkg::word_t model_pc;
logic [31:0]   rng_state;

function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// Low registers come up often so operands match and branches go both ways
function automatic rv_pkg::reg_idx_t pick_reg();
  logic [31:0] r;
  r = next_random();
  if (r[8]) begin
    return {2'b00, r[2:0]};
  end
  return r[4:0];
endfunction

function automatic rv_pkg::word_t make_insn();
  logic [31:0]      r;
  logic [31:0]      off;
  rv_pkg::reg_idx_t rd;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  logic [2:0]       f3;
  logic             alt;
  r   = next_random();
  rd  = pick_reg();
  rs1 = pick_reg();
  rs2 = pick_reg();
  f3  = r[10:8];
  alt = r[11];
  off = {{26{r[20]}}, r[19:16], 2'b00};  // Word multiple in -64..60
  case (r[3:0])
    4'd0: return {r[31:12], rd, rv_pkg::OP_LUI};
    4'd1: return {r[31:12], rd, rv_pkg::OP_AUIPC};
    4'd2, 4'd3, 4'd4, 4'd14: begin
      if (f3 == rv_pkg::F3_SLL) begin
        return {7'b0, r[24:20], rs1, f3, rd, rv_pkg::OP_IMM};
      end else if (f3 == rv_pkg::F3_SR) begin
        return {1'b0, alt, 5'b0, r[24:20], rs1, f3, rd, rv_pkg::OP_IMM};  // SRLI or SRAI
      end
      return {r[31:20], rs1, f3, rd, rv_pkg::OP_IMM};
    end
    4'd5, 4'd6, 4'd7, 4'd15: begin
      alt = alt && (f3 == rv_pkg::F3_ADD || f3 == rv_pkg::F3_SR);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    end
    4'd8, 4'd9, 4'd10: begin
      if (f3 == 3'd2 || f3 == 3'd3) begin
        f3 = f3 + 3'd4;  // Skip the two reserved branch encodings
      end
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
    end
    4'd11: return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
    4'd12: return {r[31:20], rs1, 3'b000, rd, rv_pkg::OP_JALR};
    default: return {4'b0000, 4'b1111, 4'b1111, 13'b0, rv_pkg::OP_FENCE};
  endcase
endfunction

function automatic rv_pkg::word_t alu_op(input logic [2:0] f3, input logic alt,
                                         input rv_pkg::word_t a, input rv_pkg::word_t b);
  rv_pkg::word_t res;
  case (f3)
    3'b000: res = alt ? a - b : a + b;
    3'b001: res = a << b[4:0];
    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: res = (a < b) ? 32'd1 : 32'd0;
    3'b100: res = a ^ b;
    3'b101: begin
      if (alt) begin
        res = $signed(a) >>> b[4:0];
      end else begin
        res = a >> b[4:0];
      end
    end
    3'b110: res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

task automatic clear_model();
  for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
    model_regs[i] = '0;
  end
  model_pc  = rv_pkg::RESET_PC;
  rng_state = 32'd72;
endtask

task automatic predict(input rv_pkg::word_t insn_w, output rv_pkg::retire_t ret,
                       output rv_pkg::word_t next_pc, output logic halt_exp);
  logic [2:0]    f3;
  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  logic          cond;
  f3    = insn_w[14:12];
  a     = model_regs[insn_w[19:15]];
  b     = model_regs[insn_w[24:20]];
  imm_i = {{20{insn_w[31]}}, insn_w[31:20]};
  imm_b = {{20{insn_w[31]}}, insn_w[7], insn_w[30:25], insn_w[11:8], 1'b0};
  imm_j = {{12{insn_w[31]}}, insn_w[19:12], insn_w[20], insn_w[30:21], 1'b0};
  ret      = '0;
  ret.rd   = insn_w[11:7];
  next_pc  = model_pc + 32'd4;
  halt_exp = 1'b0;
  case (insn_w[6:0])
    rv_pkg::OP_LUI: begin
      ret.we   = 1'b1;
      ret.data = {insn_w[31:12], 12'b0};
    end
    rv_pkg::OP_AUIPC: begin
      ret.we   = 1'b1;
      ret.data = model_pc + {insn_w[31:12], 12'b0};
    end
    rv_pkg::OP_IMM: begin
      ret.we   = 1'b1;
      ret.data = alu_op(f3, insn_w[30] && f3 == 3'b101, a, imm_i);  // Only SRAI uses bit 30
    end
    rv_pkg::OP_REG: begin
      ret.we   = 1'b1;
      ret.data = alu_op(f3, insn_w[30], a, b);
    end
    rv_pkg::OP_BRANCH: begin
      case (f3)
        3'b000:  cond = (a == b);
        3'b001:  cond = (a != b);
        3'b100:  cond = ($signed(a) < $signed(b));
        3'b101:  cond = ($signed(a) >= $signed(b));
        3'b110:  cond = (a < b);
        default: cond = (a >= b);
      endcase
      if (cond) begin
        next_pc = model_pc + imm_b;
      end
    end
    rv_pkg::OP_JAL: begin
      ret.we   = 1'b1;
      ret.data = model_pc + 32'd4;
      next_pc  = model_pc + imm_j;
    end
    rv_pkg::OP_JALR: begin
      ret.we   = 1'b1;
      ret.data = model_pc + 32'd4;
      next_pc  = (a + imm_i) & ~32'd1;
    end
    rv_pkg::OP_SYSTEM: halt_exp = 1'b1;
    default: ;  // FENCE does nothing
  endcase
  ret.we = ret.we && (ret.rd != 5'd0);
endtask

task automatic commit(input rv_pkg::retire_t ret, input rv_pkg::word_t next_pc);
  if (ret.we) begin
    model_regs[ret.rd] = ret.data;
  end
  model_pc = next_pc;
endtask

`endif

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_INSNS      = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSNS + 2 + 50;  // 50 cycles of margin

  localparam rv_pkg::word_t ECALL_INSN = {25'b0, rv_pkg::OP_SYSTEM};
  localparam rv_pkg::word_t ADDI_INSN  = {12'd1, 5'd0, 3'b000, 5'd5, rv_pkg::OP_IMM};

  logic            clk;
  logic            rst;
  rv_pkg::word_t   insn;
  rv_pkg::word_t   pc;
  rv_pkg::retire_t retire;
  logic            halt;

  `include "rv_model.svh"

  rv_core dut0 (
    .clk    (clk),
    .rst    (rst),
    .insn   (insn),
    .pc     (pc),
    .retire (retire),
    .halt   (halt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  // rd and data only matter when a write is expected
  task automatic check_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t act);
    if (act.we !== exp.we) begin
      $display("Fail retire.we: expected %h, actual %h", exp.we, act.we);
      stop_on_error();
    end else if (exp.we && (act.rd !== exp.rd || act.data !== exp.data)) begin
      $display("Fail retire: expected rd %h data %h, actual rd %h data %h",
               exp.rd, exp.data, act.rd, act.data);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Run timed out before the final ECALL was reached");
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rv_pkg::retire_t exp_ret;
    rv_pkg::word_t   exp_next;
    logic            exp_halt;
    rv_pkg::word_t   word;
    rst         = 1'b1;
    insn        = '0;
    clear_model();

    // Writing and halting instructions must stay silent under reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      insn = (i % 2 == 0) ? ADDI_INSN : ECALL_INSN;
      if (i > 0) begin
        check_word("pc", rv_pkg::RESET_PC, pc);
      end
      #1;
      exp_ret = '0;
      check_retire(exp_ret, retire);
      check_bit("halt", 1'b0, halt);
      @(negedge clk);
    end
    rst = 1'b0;

    for (int n = 0; n <= NUM_INSNS; n++) begin
      check_word("pc", model_pc, pc);
      if (n < NUM_INSNS) begin
        word = make_insn();
      end else begin
        word = ECALL_INSN;  // Last one ends the program
      end
      insn = word;
      predict(word, exp_ret, exp_next, exp_halt);
      #1;
      check_retire(exp_ret, retire);
      check_bit("halt", exp_halt, halt);
      commit(exp_ret, exp_next);
      @(negedge clk);
    end
    check_word("pc", model_pc, pc);  // ECALL still steps pc by 4

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
design/rv_pkg.sv
design/insn_decoder.sv
design/reg_file.sv
design/exec_alu.sv
design/branch_unit.sv
design/pc_sequencer.sv
design/rv_core.sv
bench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/insn_decoder.sv
      - design/reg_file.sv
      - design/exec_alu.sv
      - design/branch_unit.sv
      - design/pc_sequencer.sv
      - design/rv_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_rv_core.sv
